// File: src/tqv_io_macros.svh
/*
 * Address map and timing constants for the TinyQV I/O block.
 * The UART divider and time period assume a 64 MHz clock.
 * TIME_PERIOD must stay 64 because the time counter is 6 bits wide.
 */
`ifndef TQV_IO_MACROS_SVH
`define TQV_IO_MACROS_SVH

// Local register window, compared with addr[27:6] (byte address 0x8000000)
`define LOCAL_WINDOW 22'h200000

// User peripheral window, compared with addr[27:11] (2 KB at 0x8000000)
`define USER_WINDOW 17'h10000

// User register byte offsets within the user window
`define USER_REG_OUT 11'h400
`define USER_REG_IN 11'h404
`define USER_REG_IRQ 11'h408

// 64 MHz / 4 Mbit/s
`define UART_CLKS_PER_BIT 16

// Clock cycles between time pulses
`define TIME_PERIOD 64

`endif

// File: src/tqv_io_pkg.sv
/*
 * Shared types for the TinyQV I/O block.
 * Peripheral codes match addr[5:2] inside the local register window.
 * Transfer size encoding follows the core's write_n/read_n levels.
 */
package tqv_io_pkg;

    // Peripheral selected by the current data address
    typedef enum logic [3:0] {
        PERI_NONE              = 4'h0,
        PERI_GPIO_OUT_SEL      = 4'h3,
        PERI_DEBUG_UART        = 4'h6,
        PERI_DEBUG_UART_STATUS = 4'h7,
        PERI_DEBUG             = 4'hC,
        PERI_USER              = 4'hF
    } peri_sel_e;

    // Size of a core data transfer, TXN_NONE when idle
    typedef enum logic [1:0] {
        TXN_BYTE = 2'd0,
        TXN_HALF = 2'd1,
        TXN_WORD = 2'd2,
        TXN_NONE = 2'd3
    } txn_size_e;

    // Debug UART transmitter states
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

// File: src/peri_addr_decode.sv
/*
 * Data address decoder for the TinyQV I/O block.
 * The local register window overlaps the user window and wins.
 * Local addresses must be word aligned, otherwise they decode as unmapped.
 * Purely combinational; wr_en/rd_en carry no peripheral qualification.
 */
`include "tqv_io_macros.svh"

module peri_addr_decode (
    input  logic [27:0]             addr,
    input  tqv_io_pkg::txn_size_e   write_n,
    input  tqv_io_pkg::txn_size_e   read_n,
    output tqv_io_pkg::peri_sel_e   peri_sel,
    output logic                    wr_en,
    output logic                    rd_en,
    output logic [1:0]              txn_active
);

    tqv_io_pkg::peri_sel_e local_code;

    assign local_code = tqv_io_pkg::peri_sel_e'(addr[5:2]);

    always_comb begin
        peri_sel = tqv_io_pkg::PERI_NONE;
        if (addr[27:6] == `LOCAL_WINDOW) begin
            // Only aligned accesses to the listed local registers exist
            if (addr[1:0] == 2'b00) begin
                case (local_code)
                    tqv_io_pkg::PERI_GPIO_OUT_SEL,
                    tqv_io_pkg::PERI_DEBUG_UART,
                    tqv_io_pkg::PERI_DEBUG_UART_STATUS,
                    tqv_io_pkg::PERI_DEBUG:     peri_sel = local_code;
                    default:                    peri_sel = tqv_io_pkg::PERI_NONE;
                endcase
            end
        end else if (addr[27:11] == `USER_WINDOW) begin
            peri_sel = tqv_io_pkg::PERI_USER;
        end
    end

    assign wr_en = (write_n != tqv_io_pkg::TXN_NONE);
    assign rd_en = (read_n != tqv_io_pkg::TXN_NONE);

    // Read active in bit 1, write active in bit 0
    assign txn_active = {rd_en, wr_en};

    // The core never issues a read and a write in the same cycle
    always_comb begin
        a_no_wr_rd_overlap: assert #0 (!(wr_en === 1'b1 && rd_en === 1'b1))
            else $error("write and read strobes active together");
    end

endmodule

// File: src/io_control_regs.sv
/*
 * Local control registers of the TinyQV I/O block.
 * gpio_out_sel and debug_register_data take their reset values from ui_in.
 * ui_in_sync lags ui_in by two clock edges; debug_rd_r by one.
 * time_pulse fires once every TIME_PERIOD cycles.
 */
`include "tqv_io_macros.svh"

module io_control_regs (
    input  logic                    clk,
    input  logic                    rst_reg_n,
    input  logic [7:0]              ui_in,
    input  tqv_io_pkg::peri_sel_e   peri_sel,
    input  logic                    wr_en,
    input  logic [31:0]             data_in,
    input  logic [3:0]              debug_rd,
    output logic [1:0]              gpio_out_sel,
    output logic                    debug_register_data,
    output logic [3:0]              debug_rd_r,
    output logic [7:0]              ui_in_sync,
    output logic                    time_pulse
);

    logic [7:0] ui_in_meta;
    logic [5:0] time_count;

    // Output select for pins 7 and 6, plus the debug display switch
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            gpio_out_sel        <= {~ui_in[0], 1'b0};
            debug_register_data <= ui_in[1];
        end else if (wr_en) begin
            if (peri_sel == tqv_io_pkg::PERI_GPIO_OUT_SEL) begin
                gpio_out_sel <= data_in[7:6];
            end
            if (peri_sel == tqv_io_pkg::PERI_DEBUG) begin
                debug_register_data <= data_in[0];
            end
        end
    end

    // Free running time base
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            time_count <= '0;
        end else begin
            time_count <= time_count + 6'd1;
        end
    end

    assign time_pulse = (time_count == 6'(`TIME_PERIOD - 1));

    // Two stage synchronizer and debug register capture
    always_ff @(posedge clk) begin
        ui_in_meta <= ui_in;
        ui_in_sync <= ui_in_meta;
        debug_rd_r <= debug_rd;
    end

    a_time_pulse_single: assert property (
        @(posedge clk) disable iff (!rst_reg_n) time_pulse |=> !time_pulse
    ) else $error("time_pulse high on consecutive cycles");

endmodule

// File: src/debug_uart_tx.sv
/*
 * Debug UART transmitter, 8N1, LSB first.
 * Each bit lasts UART_CLKS_PER_BIT clocks, so a frame takes 160 cycles.
 * tx_start while busy is ignored; the byte is not queued.
 * uart_busy rises the cycle after the start and falls when the stop bit ends.
 */
`include "tqv_io_macros.svh"

module debug_uart_tx (
    input  logic        clk,
    input  logic        rst_reg_n,
    input  logic        tx_start,
    input  logic [7:0]  tx_data,
    output logic        uart_txd,
    output logic        uart_busy
);

    tqv_io_pkg::uart_state_e state;
    logic [3:0]              clk_cnt;
    logic [2:0]              bit_idx;
    logic [7:0]              shift_reg;
    logic                    bit_end;

    assign bit_end   = (clk_cnt == 4'(`UART_CLKS_PER_BIT - 1));
    assign uart_busy = (state != tqv_io_pkg::UART_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            state    <= tqv_io_pkg::UART_IDLE;
            uart_txd <= 1'b1;
            clk_cnt  <= '0;
            bit_idx  <= '0;
        end else begin
            // Bit timer runs only inside a frame
            if (state == tqv_io_pkg::UART_IDLE || bit_end) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 4'd1;
            end

            case (state)
                tqv_io_pkg::UART_IDLE: begin
                    if (tx_start) begin
                        state    <= tqv_io_pkg::UART_START;
                        uart_txd <= 1'b0;
                    end
                end
                tqv_io_pkg::UART_START: begin
                    if (bit_end) begin
                        state    <= tqv_io_pkg::UART_DATA;
                        uart_txd <= shift_reg[0];
                        bit_idx  <= '0;
                    end
                end
                tqv_io_pkg::UART_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state    <= tqv_io_pkg::UART_STOP;
                            uart_txd <= 1'b1;
                        end else begin
                            uart_txd <= shift_reg[0];
                            bit_idx  <= bit_idx + 3'd1;
                        end
                    end
                end
                default: begin
                    // Stop bit, line already high
                    if (bit_end) begin
                        state <= tqv_io_pkg::UART_IDLE;
                    end
                end
            endcase
        end
    end

    // Shift register moves one bit each time a bit goes out on the line
    always_ff @(posedge clk) begin
        if (state == tqv_io_pkg::UART_IDLE && tx_start) begin
            shift_reg <= tx_data;
        end else if (bit_end && state != tqv_io_pkg::UART_STOP) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        (state == tqv_io_pkg::UART_IDLE) |-> uart_txd
    ) else $error("uart_txd low while idle");

endmodule

// File: src/user_peripherals.sv
/*
 * User peripheral block: output byte, input readback, interrupt flags.
 * Reads are registered, so peri_data_ready rises one cycle after the read
 * starts and stays high while the read is held.
 * irq_flags[i] latches a rising edge on ui_in_sync[i+2].
 * Writes to IRQ clear each flag whose data bit is 1. Other offsets read 0.
 */
`include "tqv_io_macros.svh"

module user_peripherals (
    input  logic        clk,
    input  logic        rst_reg_n,
    input  logic [7:0]  ui_in_sync,
    input  logic [10:0] addr_low,
    input  logic [31:0] data_in,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic        user_sel,
    output logic [7:0]  peri_out,
    output logic [31:0] peri_data_out,
    output logic        peri_data_ready,
    output logic [5:0]  irq_flags
);

    logic        wr_active;
    logic        rd_active;
    logic        rd_pending;
    logic [5:0]  irq_prev;
    logic [5:0]  irq_rise;
    logic [5:0]  irq_clear;
    logic [31:0] rd_data;

    assign wr_active = wr_en && user_sel;
    assign rd_active = rd_en && user_sel;

    assign irq_rise  = ui_in_sync[7:2] & ~irq_prev;
    assign irq_clear = (wr_active && addr_low == `USER_REG_IRQ) ? data_in[5:0] : 6'h00;

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            peri_out   <= '0;
            irq_flags  <= '0;
            rd_pending <= 1'b0;
        end else begin
            if (wr_active && addr_low == `USER_REG_OUT) begin
                peri_out <= data_in[7:0];
            end
            // A new edge wins over a clear in the same cycle
            irq_flags  <= (irq_flags & ~irq_clear) | irq_rise;
            rd_pending <= rd_active;
        end
    end

    // Read data selection
    always_comb begin
        case (addr_low)
            `USER_REG_IN:  rd_data = {24'h0, ui_in_sync};
            `USER_REG_IRQ: rd_data = {26'h0, irq_flags};
            default:       rd_data = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        irq_prev      <= ui_in_sync[7:2];
        peri_data_out <= rd_data;
    end

    // Drops as soon as the core releases the read
    assign peri_data_ready = rd_pending && rd_active;

endmodule

// File: src/io_result_mux.sv
/*
 * Read data, ready and dedicated output pin multiplexing.
 * Unmapped reads return all ones with ready in the same cycle.
 * Only user peripheral reads wait, on peri_data_ready.
 * gpio_out_sel[1:0] holds select bits 7:6.
 */
module io_result_mux (
    input  tqv_io_pkg::peri_sel_e   peri_sel,
    input  logic [1:0]              gpio_out_sel,
    input  logic                    uart_busy,
    input  logic                    uart_txd,
    input  logic [31:0]             peri_data_out,
    input  logic                    peri_data_ready,
    input  logic [7:0]              peri_out,
    input  logic                    debug_register_data,
    input  logic [3:0]              debug_rd_r,
    input  logic [13:0]             debug_flags,
    input  logic [1:0]              txn_active,
    input  logic [3:0]              debug_sel,
    output logic [31:0]             data_out,
    output logic                    data_ready,
    output logic [7:0]              uo_out
);

    logic [15:0] debug_signals;
    logic        debug_signal;

    always_comb begin
        case (peri_sel)
            tqv_io_pkg::PERI_GPIO_OUT_SEL:      data_out = {24'h0, gpio_out_sel, 6'h0};
            tqv_io_pkg::PERI_DEBUG_UART_STATUS: data_out = {31'h0, uart_busy};
            tqv_io_pkg::PERI_USER:              data_out = peri_data_out;
            default:                            data_out = 32'hFFFF_FFFF;
        endcase
    end

    assign data_ready = (peri_sel == tqv_io_pkg::PERI_USER) ? peri_data_ready : 1'b1;

    // Core debug flags on top, bus activity in the two lowest slots
    assign debug_signals = {debug_flags, txn_active};
    assign debug_signal  = debug_signals[debug_sel];

    assign uo_out[1:0] = peri_out[1:0];
    assign uo_out[5:2] = debug_register_data ? debug_rd_r : peri_out[5:2];
    assign uo_out[6]   = gpio_out_sel[0] ? peri_out[6] : uart_txd;
    assign uo_out[7]   = gpio_out_sel[1] ? peri_out[7] : debug_signal;

endmodule

// File: src/tqv_io_top.sv
/*
 * I/O side of the TinyQV microcontroller, between the core's data port
 * and the dedicated tile pins. The core and QSPI side are external.
 * rst_n is sampled on the falling clock edge; all logic resets
 * synchronously from that registered copy.
 * ui_in[6:3] picks the debug signal shown on uo_out[7].
 */
module tqv_io_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              ui_in,
    input  logic [27:0]             addr,
    input  tqv_io_pkg::txn_size_e   write_n,
    input  tqv_io_pkg::txn_size_e   read_n,
    input  logic [31:0]             data_in,
    input  logic [13:0]             debug_flags,
    input  logic [3:0]              debug_rd,
    output logic [7:0]              uo_out,
    output logic [31:0]             data_out,
    output logic                    data_ready,
    output logic [15:0]             interrupt_req,
    output logic                    time_pulse
);

    logic                  rst_reg_n;
    tqv_io_pkg::peri_sel_e peri_sel;
    logic                  wr_en;
    logic                  rd_en;
    logic [1:0]            txn_active;
    logic [1:0]            gpio_out_sel;
    logic                  debug_register_data;
    logic [3:0]            debug_rd_r;
    logic [7:0]            ui_in_sync;
    logic                  tx_start;
    logic                  uart_txd;
    logic                  uart_busy;
    logic [7:0]            peri_out;
    logic [31:0]           peri_data_out;
    logic                  peri_data_ready;
    logic [5:0]            irq_flags;

    // Half a cycle of setup margin for the reset release
    always_ff @(negedge clk) begin
        rst_reg_n <= rst_n;
    end

    assign tx_start      = wr_en && (peri_sel == tqv_io_pkg::PERI_DEBUG_UART);
    assign interrupt_req = {8'h00, irq_flags, ui_in_sync[1:0]};

    peri_addr_decode peri_addr_decode_inst (
        .addr(addr), .write_n(write_n), .read_n(read_n),
        .peri_sel(peri_sel), .wr_en(wr_en), .rd_en(rd_en), .txn_active(txn_active)
    );

    io_control_regs io_control_regs_inst (
        .clk(clk), .rst_reg_n(rst_reg_n), .ui_in(ui_in), .peri_sel(peri_sel),
        .wr_en(wr_en), .data_in(data_in), .debug_rd(debug_rd),
        .gpio_out_sel(gpio_out_sel), .debug_register_data(debug_register_data),
        .debug_rd_r(debug_rd_r), .ui_in_sync(ui_in_sync), .time_pulse(time_pulse)
    );

    debug_uart_tx debug_uart_tx_inst (
        .clk(clk), .rst_reg_n(rst_reg_n), .tx_start(tx_start), .tx_data(data_in[7:0]),
        .uart_txd(uart_txd), .uart_busy(uart_busy)
    );

    user_peripherals user_peripherals_inst (
        .clk(clk), .rst_reg_n(rst_reg_n), .ui_in_sync(ui_in_sync), .addr_low(addr[10:0]),
        .data_in(data_in), .wr_en(wr_en), .rd_en(rd_en),
        .user_sel(peri_sel == tqv_io_pkg::PERI_USER),
        .peri_out(peri_out), .peri_data_out(peri_data_out),
        .peri_data_ready(peri_data_ready), .irq_flags(irq_flags)
    );

    io_result_mux io_result_mux_inst (
        .peri_sel(peri_sel), .gpio_out_sel(gpio_out_sel), .uart_busy(uart_busy),
        .uart_txd(uart_txd), .peri_data_out(peri_data_out),
        .peri_data_ready(peri_data_ready), .peri_out(peri_out),
        .debug_register_data(debug_register_data), .debug_rd_r(debug_rd_r),
        .debug_flags(debug_flags), .txn_active(txn_active), .debug_sel(ui_in[6:3]),
        .data_out(data_out), .data_ready(data_ready), .uo_out(uo_out)
    );

endmodule

// File: tests/tb_tqv_io.sv
/*
 * Directed testbench for tqv_io_top, playing the core's data port.
 * Inputs change on the rising edge; outputs are sampled on the falling edge.
 * Expects ui_in[0] high and ui_in[1] low during reset.
 * Random data comes from $urandom with seed 1.
 */
`include "tqv_io_macros.svh"

module tb_tqv_io;

    localparam int CLK_PERIOD = 10;
    localparam int READ_LIMIT = 16;
    localparam logic [27:0] UNMAPPED_ADDR = 28'h0000100;

    // Rough cycle budget per test, the watchdog adds a margin on top
    localparam int RESET_CYCLES = 10;
    localparam int STATE_CYCLES = 20;
    localparam int DECODE_CYCLES = 40;
    localparam int UART_CYCLES = 10 * `UART_CLKS_PER_BIT + 40;
    localparam int USER_CYCLES = 60;
    localparam int IRQ_CYCLES = 60;
    localparam int TIME_CYCLES = 3 * `TIME_PERIOD;
    localparam int DEBUG_SEL_CYCLES = 14 * 4 + 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STATE_CYCLES + DECODE_CYCLES + UART_CYCLES
        + USER_CYCLES + IRQ_CYCLES + TIME_CYCLES + DEBUG_SEL_CYCLES + 5000;

    logic                  clk;
    logic                  rst_n;
    logic [7:0]            ui_in;
    logic [27:0]           addr;
    tqv_io_pkg::txn_size_e write_n;
    tqv_io_pkg::txn_size_e read_n;
    logic [31:0]           data_in;
    logic [13:0]           debug_flags;
    logic [3:0]            debug_rd;
    logic [7:0]            uo_out;
    logic [31:0]           data_out;
    logic                  data_ready;
    logic [15:0]           interrupt_req;
    logic                  time_pulse;

    int          error_count;
    int          check_count;

    tqv_io_top tqv_io_top_inst (
        .clk(clk), .rst_n(rst_n), .ui_in(ui_in), .addr(addr), .write_n(write_n),
        .read_n(read_n), .data_in(data_in), .debug_flags(debug_flags), .debug_rd(debug_rd),
        .uo_out(uo_out), .data_out(data_out), .data_ready(data_ready),
        .interrupt_req(interrupt_req), .time_pulse(time_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [27:0] local_addr(input tqv_io_pkg::peri_sel_e code);
        return {`LOCAL_WINDOW, code, 2'b00};
    endfunction

    function automatic logic [27:0] user_addr(input logic [10:0] offset);
        return {`USER_WINDOW, offset};
    endfunction

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input logic [27:0] a, input logic [31:0] d);
        @(posedge clk);
        addr    <= a;
        data_in <= d;
        write_n <= tqv_io_pkg::TXN_WORD;
        @(posedge clk);
        write_n <= tqv_io_pkg::TXN_NONE;
    endtask

    // Holds the read until data_ready, reports whether it came in the first cycle
    task automatic bus_read(input logic [27:0] a, output logic [31:0] d, output logic same_cycle);
        int waited;
        @(posedge clk);
        addr   <= a;
        read_n <= tqv_io_pkg::TXN_WORD;
        waited = 0;
        @(negedge clk);
        while (data_ready !== 1'b1 && waited < READ_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (data_ready !== 1'b1) begin
            error_count++;
            $display("read of address %07h got no data_ready within %0d cycles", a, READ_LIMIT);
        end
        same_cycle = (waited == 0);
        d = data_out;
        @(posedge clk);
        read_n <= tqv_io_pkg::TXN_NONE;
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        logic        ready_now;
        bus_read(local_addr(tqv_io_pkg::PERI_GPIO_OUT_SEL), rd, ready_now);
        check_word("output select after reset", rd, 32'h0);
        @(negedge clk);
        check_bit("idle uart line on uo_out[6]", uo_out[6], 1'b1);
        bus_read(local_addr(tqv_io_pkg::PERI_DEBUG_UART_STATUS), rd, ready_now);
        check_word("uart status after reset", rd, 32'h0);
    endtask

    task automatic test_decode();
        logic [31:0] rd;
        logic        ready_now;
        logic [7:0]  b;
        bus_read(UNMAPPED_ADDR, rd, ready_now);
        check_word("unmapped read", rd, 32'hFFFF_FFFF);
        check_bit("unmapped ready in same cycle", ready_now, 1'b1);
        b = 8'($urandom);
        bus_write(local_addr(tqv_io_pkg::PERI_GPIO_OUT_SEL), {24'h0, b});
        bus_read(local_addr(tqv_io_pkg::PERI_GPIO_OUT_SEL), rd, ready_now);
        check_word("output select readback", rd, {24'h0, b[7:6], 6'h0});
        check_bit("local ready in same cycle", ready_now, 1'b1);
        // Misaligned local addresses fall out of the window
        bus_read(local_addr(tqv_io_pkg::PERI_GPIO_OUT_SEL) | 28'h1, rd, ready_now);
        check_word("misaligned local read", rd, 32'hFFFF_FFFF);
        bus_read(local_addr(tqv_io_pkg::PERI_GPIO_OUT_SEL) | 28'h2, rd, ready_now);
        check_word("misaligned local read", rd, 32'hFFFF_FFFF);
        bus_write(local_addr(tqv_io_pkg::PERI_GPIO_OUT_SEL), 32'h0);
    endtask

    task automatic test_debug_uart();
        logic [7:0]              b;
        logic                    exp_line;
        tqv_io_pkg::uart_state_e phase;
        b = 8'($urandom);
        bus_write(local_addr(tqv_io_pkg::PERI_DEBUG_UART), {24'h0, b});
        // Status read held across the whole frame
        addr   <= local_addr(tqv_io_pkg::PERI_DEBUG_UART_STATUS);
        read_n <= tqv_io_pkg::TXN_WORD;
        repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
        for (int k = 0; k < 10; k++) begin
            if (k == 0) begin
                phase = tqv_io_pkg::UART_START;
            end else if (k == 9) begin
                phase = tqv_io_pkg::UART_STOP;
            end else begin
                phase = tqv_io_pkg::UART_DATA;
            end
            case (phase)
                tqv_io_pkg::UART_START: exp_line = 1'b0;
                tqv_io_pkg::UART_DATA:  exp_line = b[k-1];
                default:                exp_line = 1'b1;
            endcase
            check_bit($sformatf("uart frame bit %0d", k), uo_out[6], exp_line);
            check_word("uart status during frame", data_out, 32'h1);
            if (k < 9) begin
                repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            end
        end
        // Move on to just past the end of the stop bit
        repeat (`UART_CLKS_PER_BIT - `UART_CLKS_PER_BIT / 2 + 1) @(negedge clk);
        check_word("uart status after frame", data_out, 32'h0);
        @(posedge clk);
        read_n <= tqv_io_pkg::TXN_NONE;
    endtask

    task automatic test_user_out();
        logic [7:0] v;
        logic [3:0] r;
        v = 8'($urandom);
        r = 4'($urandom);
        if (r == 4'h0) begin
            r = 4'h5;
        end
        bus_write(user_addr(`USER_REG_OUT), {24'h0, v});
        bus_write(local_addr(tqv_io_pkg::PERI_GPIO_OUT_SEL), 32'hC0);
        @(negedge clk);
        check_byte("pins with debug switch off", uo_out, v);
        bus_write(local_addr(tqv_io_pkg::PERI_DEBUG), 32'h1);
        @(posedge clk);
        debug_rd <= r;
        @(negedge clk);
        check_byte("pins before debug_rd capture", uo_out, {v[7:6], 4'h0, v[1:0]});
        @(negedge clk);
        check_byte("pins with debug switch on", uo_out, {v[7:6], r, v[1:0]});
        bus_write(local_addr(tqv_io_pkg::PERI_DEBUG), 32'h0);
        bus_write(local_addr(tqv_io_pkg::PERI_GPIO_OUT_SEL), 32'h0);
        debug_rd <= 4'h0;
    endtask

    task automatic test_user_in();
        logic [7:0] val;
        val = 8'($urandom);
        @(posedge clk);
        ui_in <= val;
        repeat (3) @(posedge clk);
        addr   <= user_addr(`USER_REG_IN);
        read_n <= tqv_io_pkg::TXN_WORD;
        @(negedge clk);
        check_bit("user read ready in first cycle", data_ready, 1'b0);
        repeat (2) begin
            @(negedge clk);
            check_bit("user read ready while held", data_ready, 1'b1);
            check_word("user input readback", data_out, {24'h0, val});
        end
        @(posedge clk);
        read_n <= tqv_io_pkg::TXN_NONE;
    endtask

    task automatic test_interrupts();
        logic [31:0] rd;
        logic        ready_now;
        @(posedge clk);
        ui_in <= 8'h00;
        repeat (4) @(posedge clk);
        bus_write(user_addr(`USER_REG_IRQ), 32'h3F);
        bus_read(user_addr(`USER_REG_IRQ), rd, ready_now);
        check_word("irq flags after clearing all", rd, 32'h0);
        @(posedge clk);
        ui_in <= 8'h10;
        // Two synchronizer edges, then one for the edge detect
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_word("interrupt_req after ui_in[4] rise", {16'h0, interrupt_req}, 32'h10);
        bus_read(user_addr(`USER_REG_IRQ), rd, ready_now);
        check_word("irq flags after ui_in[4] rise", rd, 32'h4);
        bus_write(user_addr(`USER_REG_IRQ), 32'h4);
        @(negedge clk);
        check_word("interrupt_req after clear", {16'h0, interrupt_req}, 32'h0);
        bus_read(user_addr(`USER_REG_IRQ), rd, ready_now);
        check_word("irq flags after clear", rd, 32'h0);
        @(posedge clk);
        ui_in <= 8'h13;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_word("interrupt_req level inputs", {16'h0, interrupt_req}, 32'h3);
        @(posedge clk);
        ui_in <= 8'h00;
    endtask

    task automatic test_time_pulse();
        int waited;
        int gap;
        waited = 0;
        @(negedge clk);
        while (time_pulse !== 1'b1 && waited < 2 * `TIME_PERIOD) begin
            @(negedge clk);
            waited++;
        end
        if (time_pulse !== 1'b1) begin
            error_count++;
            $display("time_pulse never went high within %0d cycles", 2 * `TIME_PERIOD);
        end else begin
            gap = 1;
            @(negedge clk);
            while (time_pulse !== 1'b1 && gap < 2 * `TIME_PERIOD) begin
                @(negedge clk);
                gap++;
            end
            check_word("cycles between time pulses", 32'(gap), 32'(`TIME_PERIOD));
        end
    endtask

    task automatic test_debug_select();
        logic [13:0] flags;
        flags = 14'($urandom);
        for (int k = 2; k < 16; k++) begin
            @(posedge clk);
            ui_in       <= {1'b0, 4'(k), 3'b000};
            debug_flags <= flags;
            @(negedge clk);
            check_bit($sformatf("uo_out[7] for debug index %0d", k), uo_out[7], flags[k-2]);
            @(posedge clk);
            debug_flags <= ~flags;
            @(negedge clk);
            check_bit($sformatf("uo_out[7] for debug index %0d", k), uo_out[7], ~flags[k-2]);
        end
        // Bus activity slots, read active at index 1 and write active at index 0
        @(posedge clk);
        ui_in  <= {1'b0, 4'd1, 3'b000};
        addr   <= UNMAPPED_ADDR;
        read_n <= tqv_io_pkg::TXN_WORD;
        @(negedge clk);
        check_bit("uo_out[7] shows read active", uo_out[7], 1'b1);
        @(posedge clk);
        read_n  <= tqv_io_pkg::TXN_NONE;
        ui_in   <= {1'b0, 4'd0, 3'b000};
        write_n <= tqv_io_pkg::TXN_WORD;
        @(negedge clk);
        check_bit("uo_out[7] shows write active", uo_out[7], 1'b1);
        @(posedge clk);
        write_n <= tqv_io_pkg::TXN_NONE;
        @(negedge clk);
        check_bit("uo_out[7] with bus idle", uo_out[7], 1'b0);
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        void'($urandom(1));
        rst_n       = 1'b0;
        ui_in       = 8'h01;
        addr        = '0;
        write_n     = tqv_io_pkg::TXN_NONE;
        read_n      = tqv_io_pkg::TXN_NONE;
        data_in     = '0;
        debug_flags = '0;
        debug_rd    = '0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        test_reset_state();
        test_decode();
        test_debug_uart();
        test_user_out();
        test_user_in();
        test_interrupts();
        test_time_pulse();
        test_debug_select();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/tqv_io_pkg.sv
src/peri_addr_decode.sv
src/io_control_regs.sv
src/debug_uart_tx.sv
src/user_peripherals.sv
src/io_result_mux.sv
src/tqv_io_top.sv
tests/tb_tqv_io.sv
